/* hdl/auto_correlator.sv */
// self-lag and ones counters for one input
module auto_correlator #(
	parameter int LAG_AUTO = 2,
	parameter int LAG_CROSS = 2,
	parameter int SAT_MAX = 65535
) (
	input logic clk,
	input logic rst_n,
	input logic acc_en,
	input logic last,
	input logic clear,
	input corr_pkg::line_cfg_t cfg,
	input logic [corr_pkg::auto_taps(LAG_CROSS, LAG_AUTO)-1:0] taps,
	output corr_pkg::count_t [LAG_AUTO:0] dump
);

	localparam int TAP_N = corr_pkg::auto_taps(LAG_CROSS, LAG_AUTO);
	localparam int IDX_W = $clog2(TAP_N);

	logic [IDX_W-1:0] idx_c;
	logic centre;
	logic line_on;

	// same centre tap as the baselines use
	assign idx_c = IDX_W'(cfg.delay) + IDX_W'(LAG_CROSS - 1);
	assign centre = taps[idx_c];
	assign line_on = acc_en & cfg.enable;

	// last slot is the ones counter
	for (genvar l = 0; l <= LAG_AUTO; l++) begin : g_cnt
		logic hit;
		corr_pkg::count_t cnt;
		corr_pkg::count_t nxt;

		if (l < LAG_AUTO) begin : g_lag
			logic [IDX_W-1:0] idx_l;

			assign idx_l = idx_c + IDX_W'(l); // older sample
			assign hit = line_on & (centre == taps[idx_l]);
		end else begin : g_ones
			assign hit = line_on & centre;
		end

		assign nxt = corr_pkg::sat_inc(cnt, hit, corr_pkg::count_t'(SAT_MAX));
		assign dump[l] = nxt;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt <= '0;
			end else if (clear) begin
				cnt <= '0;
			end else if (acc_en) begin
				cnt <= last ? '0 : nxt;
			end
		end
	end

endmodule

/* hdl/baseline_correlator.sv */
// cross-lag agreement counters for one baseline
module baseline_correlator #(
	parameter int LAG_CROSS = 2,
	parameter int SAT_MAX = 65535
) (
	input logic clk,
	input logic rst_n,
	input logic acc_en,
	input logic last,
	input logic clear,
	input corr_pkg::line_cfg_t cfg_a,
	input corr_pkg::line_cfg_t cfg_b,
	input logic [corr_pkg::cross_taps(LAG_CROSS)-1:0] taps_a,
	input logic [corr_pkg::cross_taps(LAG_CROSS)-1:0] taps_b,
	output corr_pkg::count_t [2*LAG_CROSS-2:0] dump
);

	localparam int NUM_LAGS = 2 * LAG_CROSS - 1;
	localparam int TAP_N = corr_pkg::cross_taps(LAG_CROSS);
	localparam int IDX_W = $clog2(TAP_N);

	logic [IDX_W-1:0] idx_a;
	logic bit_a;
	logic both_on;

	assign idx_a = IDX_W'(cfg_a.delay) + IDX_W'(LAG_CROSS - 1); // centre tap
	assign bit_a = taps_a[idx_a];
	assign both_on = acc_en & cfg_a.enable & cfg_b.enable;

	// c = 0 is the most negative lag
	for (genvar c = 0; c < NUM_LAGS; c++) begin : g_lag
		logic [IDX_W-1:0] idx_b;
		logic hit;
		corr_pkg::count_t cnt;
		corr_pkg::count_t nxt;

		// positive lags read newer samples on line b
		assign idx_b = IDX_W'(cfg_b.delay) + IDX_W'(NUM_LAGS - 1 - c);
		assign hit = both_on & (bit_a == taps_b[idx_b]);
		assign nxt = corr_pkg::sat_inc(cnt, hit, corr_pkg::count_t'(SAT_MAX));
		assign dump[c] = nxt;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt <= '0;
			end else if (clear) begin
				cnt <= '0;
			end else if (acc_en) begin
				cnt <= last ? '0 : nxt; // restart after the frame copy
			end
		end
	end

endmodule

/* hdl/corr_pkg.sv */
// one-bit correlator types
package corr_pkg;

	localparam int COUNT_W = 16;
	localparam int DELAY_W = 3;
	localparam int MAX_DELAY = 7; // largest programmable line delay

	typedef logic sample_t; // one-bit digitized sample
	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [DELAY_W-1:0] delay_t;

	typedef struct packed {
		logic enable;
		delay_t delay;
	} line_cfg_t;

	function automatic int max_int(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// baseline taps span the delay and the whole cross lag range
	function automatic int cross_taps(input int lag_cross);
		return MAX_DELAY + 2 * lag_cross - 1;
	endfunction

	function automatic int auto_taps(input int lag_cross, input int lag_auto);
		return MAX_DELAY + lag_cross + lag_auto - 1;
	endfunction

	// delay line must cover both readers
	function automatic int line_depth(input int lag_cross, input int lag_auto);
		return max_int(cross_taps(lag_cross), auto_taps(lag_cross, lag_auto));
	endfunction

	// baselines, then auto lags, then ones counts
	function automatic int frame_len(input int n, input int lag_cross, input int lag_auto);
		return n * (n - 1) / 2 * (2 * lag_cross - 1) + n * lag_auto + n;
	endfunction

	function automatic count_t sat_inc(input count_t c, input logic hit, input count_t sat_max);
		return (hit && c < sat_max) ? c + count_t'(1) : c;
	endfunction

endpackage

/* hdl/correlator.sv */
// delay lines, correlator array and frame register
module correlator #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS = 2,
	parameter int LAG_AUTO = 2,
	parameter int SAT_MAX = 65535
) (
	input logic clk,
	input logic rst_n,
	input logic smp,
	input logic acc_en,
	input logic last,
	input logic clear,
	input corr_pkg::sample_t [NUM_INPUTS-1:0] samples,
	input corr_pkg::line_cfg_t [NUM_INPUTS-1:0] line_cfg,
	output corr_pkg::count_t [corr_pkg::frame_len(NUM_INPUTS, LAG_CROSS, LAG_AUTO)-1:0] frame,
	output logic frame_valid
);

	localparam int NUM_LAGS = 2 * LAG_CROSS - 1;
	localparam int NUM_BL = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int FRAME_LEN = corr_pkg::frame_len(NUM_INPUTS, LAG_CROSS, LAG_AUTO);
	localparam int AUTO_BASE = NUM_BL * NUM_LAGS;
	localparam int ONES_BASE = AUTO_BASE + NUM_INPUTS * LAG_AUTO;
	localparam int DEPTH = corr_pkg::line_depth(LAG_CROSS, LAG_AUTO);
	localparam int XTAP_N = corr_pkg::cross_taps(LAG_CROSS);
	localparam int ATAP_N = corr_pkg::auto_taps(LAG_CROSS, LAG_AUTO);

	logic [DEPTH-1:0] line_taps [NUM_INPUTS];
	corr_pkg::count_t [FRAME_LEN-1:0] frame_d;
	logic dump_now;

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
		corr_pkg::count_t [LAG_AUTO:0] au_dump;

		delay_line #(.DEPTH(DEPTH)) u_delay (
			.clk(clk),
			.rst_n(rst_n),
			.smp(smp),
			.din(samples[i]),
			.taps(line_taps[i])
		);

		auto_correlator #(
			.LAG_AUTO(LAG_AUTO),
			.LAG_CROSS(LAG_CROSS),
			.SAT_MAX(SAT_MAX)
		) u_auto (
			.clk(clk),
			.rst_n(rst_n),
			.acc_en(acc_en),
			.last(last),
			.clear(clear),
			.cfg(line_cfg[i]),
			.taps(line_taps[i][ATAP_N-1:0]),
			.dump(au_dump)
		);

		assign frame_d[AUTO_BASE + i * LAG_AUTO +: LAG_AUTO] = au_dump[LAG_AUTO-1:0];
		assign frame_d[ONES_BASE + i] = au_dump[LAG_AUTO];
	end

	// pairs in order (0,1),(0,2)..(N-2,N-1)
	for (genvar i = 0; i < NUM_INPUTS - 1; i++) begin : g_row
		for (genvar j = i + 1; j < NUM_INPUTS; j++) begin : g_pair
			localparam int BL = i * (2 * NUM_INPUTS - i - 1) / 2 + (j - i - 1);

			corr_pkg::count_t [NUM_LAGS-1:0] bl_dump;

			baseline_correlator #(
				.LAG_CROSS(LAG_CROSS),
				.SAT_MAX(SAT_MAX)
			) u_bl (
				.clk(clk),
				.rst_n(rst_n),
				.acc_en(acc_en),
				.last(last),
				.clear(clear),
				.cfg_a(line_cfg[i]),
				.cfg_b(line_cfg[j]),
				.taps_a(line_taps[i][XTAP_N-1:0]),
				.taps_b(line_taps[j][XTAP_N-1:0]),
				.dump(bl_dump)
			);

			assign frame_d[BL * NUM_LAGS +: NUM_LAGS] = bl_dump;
		end
	end

	assign dump_now = acc_en & last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= dump_now;
			if (dump_now) frame <= frame_d; // overwrites any unread frame
		end
	end

endmodule

/* hdl/correlator_top.sv */
// one-bit intensity correlator top
module correlator_top #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS = 2,
	parameter int LAG_AUTO = 2,
	parameter int INTEG_LEN = 256,
	parameter int SAT_MAX = 65535
) (
	input logic clk,
	input logic rst_n,
	input logic smp,
	input corr_pkg::sample_t [NUM_INPUTS-1:0] samples,
	input corr_pkg::line_cfg_t [NUM_INPUTS-1:0] line_cfg,
	input logic enable,
	output corr_pkg::count_t [corr_pkg::frame_len(NUM_INPUTS, LAG_CROSS, LAG_AUTO)-1:0] frame,
	output logic frame_valid
);

	logic acc_en;
	logic last;
	logic clear;

	integration_ctrl #(.INTEG_LEN(INTEG_LEN)) u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.smp(smp),
		.acc_en(acc_en),
		.last(last),
		.clear(clear)
	);

	correlator #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_CROSS(LAG_CROSS),
		.LAG_AUTO(LAG_AUTO),
		.SAT_MAX(SAT_MAX)
	) u_corr (
		.clk(clk),
		.rst_n(rst_n),
		.smp(smp),
		.acc_en(acc_en),
		.last(last),
		.clear(clear),
		.samples(samples),
		.line_cfg(line_cfg),
		.frame(frame),
		.frame_valid(frame_valid)
	);

endmodule

/* hdl/delay_line.sv */
// per-input sample delay line
module delay_line #(
	parameter int DEPTH = 10
) (
	input logic clk,
	input logic rst_n,
	input logic smp,
	input corr_pkg::sample_t din,
	output logic [DEPTH-1:0] taps
);

	// tap 0 holds the newest sample
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			taps <= '0;
		end else if (smp) begin
			taps <= {taps[DEPTH-2:0], din};
		end
	end

endmodule

/* hdl/integration_ctrl.sv */
// integration window control
module integration_ctrl #(
	parameter int INTEG_LEN = 256
) (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic smp,
	output logic acc_en,
	output logic last,
	output logic clear
);

	localparam int CNT_W = (INTEG_LEN > 1) ? $clog2(INTEG_LEN) : 1;

	logic [CNT_W-1:0] strobe_cnt;
	logic final_smp;

	assign final_smp = (strobe_cnt == CNT_W'(INTEG_LEN - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strobe_cnt <= '0;
			acc_en <= 1'b0;
			last <= 1'b0;
			clear <= 1'b0;
		end else begin
			clear <= ~enable;
			acc_en <= smp & enable; // lines up with the shifted taps
			last <= smp & enable & final_smp;
			if (!enable) begin
				strobe_cnt <= '0;
			end else if (smp) begin
				// wrap at the end of the window
				strobe_cnt <= final_smp ? '0 : strobe_cnt + 1'b1;
			end
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module tb_correlator -o tb_correlator
out=$(./obj_dir/tb_correlator)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"

/* tests/correlator_vectors.txt */
# name mode(0 reset first, 1 continue, 2 reset and aborted window) gap cfg0..cfg3 as hex {enable,delay}
# then 8 sample rows (bits input3..input0), 18 baseline counts, 8 auto lag counts, 4 ones counts
same_streams 0 1 8 8 8 8
1111 1111 0000 1111 0000 0000 1111 1111
3 6 3 3 6 3 3 6 3 3 6 3 3 6 3 3 6 3
6 3 6 3 6 3 6 3 4 4 4 4

delay_peak 0 2 9 8 0 0
1111 1111 0000 1111 0000 0000 1111 1111
6 3 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 4 6 3 0 0 0 0 3 4 0 0

disabled_lines 0 1 8 3 8 0
1111 1111 0000 1111 0000 0000 1111 1111
0 0 0 3 6 3 0 0 0 0 0 0 0 0 0 0 0 0
6 3 0 0 6 3 0 0 4 0 4 0

b2b_first 0 0 8 8 8 8
1111 0000 0000 0000 0000 0000 0000 1111
6 6 5 6 6 5 6 6 5 6 6 5 6 6 5 6 6 5
6 6 6 6 6 6 6 6 1 1 1 1

b2b_second 1 0 8 8 8 8
0000 1111 0000 0000 1111 0000 1111 0000
1 6 1 1 6 1 1 6 1 1 6 1 1 6 1 1 6 1
6 1 6 1 6 1 6 1 4 4 4 4

enable_drop 2 1 8 8 8 8
1111 1111 0000 1111 0000 0000 1111 1111
3 6 3 3 6 3 3 6 3 3 6 3 3 6 3 3 6 3
6 3 6 3 6 3 6 3 4 4 4 4

/* tests/tb_checks.svh */
// correlator testbench checks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// one frame entry against its expected count
task automatic check_count(
	input string name,
	input int idx,
	input corr_pkg::count_t exp_val,
	input corr_pkg::count_t act_val
);
	if (exp_val !== act_val) begin
		$display("FAIL %0s frame[%0d] expected %0d actual %0d", name, idx, exp_val, act_val);
		value_errs++;
	end
endtask

task automatic check_frame_valid(input string name, input logic exp_val, input logic act_val);
	if (exp_val !== act_val) begin
		$display("FAIL %0s frame_valid expected %0b actual %0b", name, exp_val, act_val);
		value_errs++;
	end
endtask

// polls one time unit after each edge
task automatic wait_frame(input string name, output bit seen);
	int n;

	seen = 1'b0;
	n = 0;
	while (!seen && n < 50) begin
		@(posedge clk);
		#1;
		n++;
		if (frame_valid) seen = 1'b1;
	end
	if (!seen) begin
		$display("timeout: test %0s saw no frame_valid pulse within 50 cycles", name);
		timeout_errs++;
	end
endtask

`endif

/* tests/tb_correlator.sv */
// correlator testbench
module tb_correlator;

	localparam int NUM_INPUTS = 4;
	localparam int LAG_CROSS = 2;
	localparam int LAG_AUTO = 2;
	localparam int INTEG_LEN = 8;
	localparam int SAT_MAX = 6;
	localparam int FRAME_LEN = 30; // 18 baseline, 8 auto lag and 4 ones counts

	logic clk;
	logic rst_n;
	logic smp;
	logic enable;
	corr_pkg::sample_t [NUM_INPUTS-1:0] samples;
	corr_pkg::line_cfg_t [NUM_INPUTS-1:0] line_cfg;
	corr_pkg::count_t [FRAME_LEN-1:0] frame;
	logic frame_valid;

	int value_errs;
	int timeout_errs;
	logic [3:0] row_vec [INTEG_LEN];
	int exp_vec [FRAME_LEN];

	correlator_top #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_CROSS(LAG_CROSS),
		.LAG_AUTO(LAG_AUTO),
		.INTEG_LEN(INTEG_LEN),
		.SAT_MAX(SAT_MAX)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.smp(smp),
		.samples(samples),
		.line_cfg(line_cfg),
		.enable(enable),
		.frame(frame),
		.frame_valid(frame_valid)
	);

	`include "tb_checks.svh"

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic apply_reset();
		rst_n = 1'b0;
		smp = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
	endtask

	task automatic drive_strobe(input logic [3:0] row);
		@(posedge clk);
		#2;
		smp = 1'b1;
		samples = row; // leftmost bit is input 3
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2 smp = 1'b0;
		end
	endtask

	task automatic run_test(input string name, input int mode, input int gap);
		bit seen;

		if (mode != 1) apply_reset();
		if (mode == 2) begin
			// partial window of zeros that gets aborted
			repeat (3) drive_strobe(4'b0000);
			idle_cycles(1);
			enable = 1'b0;
			idle_cycles(3);
			enable = 1'b1;
			idle_cycles(3);
		end
		for (int r = 0; r < INTEG_LEN; r++) begin
			drive_strobe(row_vec[r]);
			if (r < INTEG_LEN - 1) idle_cycles(gap);
		end
		idle_cycles(1);
		wait_frame(name, seen);
		if (seen) begin
			for (int k = 0; k < FRAME_LEN; k++)
				check_count(name, k, corr_pkg::count_t'(exp_vec[k]), frame[k]);
			@(posedge clk);
			#1 check_frame_valid(name, 1'b0, frame_valid); // single cycle pulse
		end
	endtask

	initial begin : watchdog
		for (int c = 0; c < 20000; c++) @(posedge clk);
		$display("timeout: simulation ran past its cycle limit");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : main
		integer fd;
		integer code;
		logic [8*32-1:0] name_buf;
		logic [8*256-1:0] line_buf;
		int mode;
		int gap;
		logic [3:0] cfg_raw [NUM_INPUTS];
		bit done;

		rst_n = 1'b0;
		smp = 1'b0;
		enable = 1'b0;
		samples = '0;
		line_cfg = '0;
		value_errs = 0;
		timeout_errs = 0;
		done = 1'b0;
		fd = $fopen("tests/correlator_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/correlator_vectors.txt");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			apply_reset();
			enable = 1'b1;
			// idle after reset gives no pulse and an empty frame
			repeat (20) begin
				@(posedge clk);
				#1 check_frame_valid("reset_idle", 1'b0, frame_valid);
			end
			for (int k = 0; k < FRAME_LEN; k++)
				check_count("reset_idle", k, '0, frame[k]);

			code = $fgets(line_buf, fd); // two column comment lines
			code = $fgets(line_buf, fd);
			while (!done) begin
				code = $fscanf(fd, "%s %d %d %h %h %h %h", name_buf, mode, gap,
					cfg_raw[0], cfg_raw[1], cfg_raw[2], cfg_raw[3]);
				if (code != 7) begin
					done = 1'b1;
				end else begin
					#1; // back to the drive offset
					for (int i = 0; i < NUM_INPUTS; i++)
						line_cfg[i] = corr_pkg::line_cfg_t'(cfg_raw[i]);
					for (int r = 0; r < INTEG_LEN; r++)
						code = $fscanf(fd, "%b", row_vec[r]);
					for (int k = 0; k < FRAME_LEN; k++)
						code = $fscanf(fd, "%d", exp_vec[k]);
					run_test($sformatf("%0s", name_buf), mode, gap);
				end
			end
			$fclose(fd);

			$display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
			if (value_errs == 0 && timeout_errs == 0) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+tests
hdl/corr_pkg.sv
hdl/delay_line.sv
hdl/integration_ctrl.sv
hdl/baseline_correlator.sv
hdl/auto_correlator.sv
hdl/correlator.sv
hdl/correlator_top.sv
tests/tb_correlator.sv
